// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     = --binary --timing
TOP       = tb_aib_link
FILELIST  = aib_link.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard test/*.svh)
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

// ==== aib_link.f ====
+incdir+test
src/aib_pkg.sv
src/aib_sideband_sr.sv
src/aib_cal.sv
src/aib_sm.sv
src/aib_io.sv
src/aib_channel.sv
src/aib_link.sv
test/tb_aib_link.sv

// ==== src/aib_cal.sv ====
/*
 * Calibration timing model
 * Raises done a fixed number of cycles after a level request,
 * standing in for the duty-cycle corrector or the DLL.
 */
`timescale 1ns/1ps

module aib_cal #(
    parameter int CAL_CYCLES = 12
) (
    input  logic osc_clk,
    input  logic rst,
    input  logic req,
    output logic done
);

    localparam int CNT_W = $clog2(CAL_CYCLES + 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge osc_clk) begin
        if (rst || !req) begin
            cnt  <= '0;
            done <= 1'b0;  // drops the cycle after req falls
        end else if (cnt == CNT_W'(CAL_CYCLES)) begin
            done <= 1'b1;  // counter saturates here
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// ==== src/aib_channel.sv ====
/*
 * AIB channel
 * Link-up sequencer, calibration models, sideband and data path
 * for one side of the link, master or slave.
 */
`timescale 1ns/1ps

module aib_channel import aib_pkg::*; #(
    parameter bit  IS_MASTER  = 1'b1,
    parameter int  DATAWIDTH  = 20,
    parameter int  DCC_CYCLES = 12,
    parameter int  DLL_CYCLES = 20,
    parameter type LOC_T      = ms_sr_t,
    parameter type FAR_T      = sl_sr_t
) (
    input  logic                   osc_clk,
    input  logic                   rst,
    input  logic                   config_done,
    input  logic                   tx_dcc_dll_lock_req,
    input  logic                   rx_dcc_dll_lock_req,
    input  logic [$bits(LOC_T)-$bits(link_status_t)-1:0] user_cntl,
    output FAR_T                   sr_tomac,
    output logic                   tx_transfer_en,
    output logic                   rx_transfer_en,
    input  logic                   itxen,
    input  logic [DATAWIDTH-1:0]   idat0,
    input  logic [DATAWIDTH-1:0]   idat1,
    output logic [DATAWIDTH-1:0]   data_out0,
    output logic [DATAWIDTH-1:0]   data_out1,
    input  logic                   mac_rdy,
    output logic                   fs_mac_rdy,
    output sb_pins_t               sb_tx,
    input  sb_pins_t               sb_rx,
    output logic [2*DATAWIDTH-1:0] pad_tx,
    input  logic [2*DATAWIDTH-1:0] pad_rx,
    output logic                   rstn_pad_tx,
    input  logic                   rstn_pad_rx
);

    localparam int ST_W = $bits(link_status_t);

    link_status_t status;
    link_status_t far_status;
    LOC_T         loc_frame;
    logic         dcc_req;
    logic         dcc_done;
    logic         dll_req;
    logic         dll_lock;

    // status sits in the top bits of every frame
    assign loc_frame  = LOC_T'({status, user_cntl});
    assign far_status = link_status_t'(sr_tomac[$bits(FAR_T)-1 -: ST_W]);

    assign tx_transfer_en = status.tx_transfer_en;
    assign rx_transfer_en = status.rx_transfer_en;

    aib_sm #(.IS_MASTER(IS_MASTER)) u_sm (
        .osc_clk             (osc_clk),
        .rst                 (rst),
        .config_done         (config_done),
        .tx_dcc_dll_lock_req (tx_dcc_dll_lock_req),
        .rx_dcc_dll_lock_req (rx_dcc_dll_lock_req),
        .far_status          (far_status),
        .dcc_req             (dcc_req),
        .dcc_done            (dcc_done),
        .dll_req             (dll_req),
        .dll_lock            (dll_lock),
        .status              (status)
    );

    aib_sideband_sr #(.TX_T(LOC_T), .RX_T(FAR_T)) u_sb (
        .osc_clk   (osc_clk),
        .rst       (rst),
        .frame_out (loc_frame),
        .frame_in  (sr_tomac),
        .sb_tx     (sb_tx),
        .sb_rx     (sb_rx)
    );

    aib_cal #(.CAL_CYCLES(DCC_CYCLES)) u_dcc (  // tx duty-cycle cal
        .osc_clk (osc_clk),
        .rst     (rst),
        .req     (dcc_req),
        .done    (dcc_done)
    );

    aib_cal #(.CAL_CYCLES(DLL_CYCLES)) u_dll (  // rx dll lock
        .osc_clk (osc_clk),
        .rst     (rst),
        .req     (dll_req),
        .done    (dll_lock)
    );

    aib_io #(.DATAWIDTH(DATAWIDTH)) u_io (
        .osc_clk        (osc_clk),
        .rst            (rst),
        .itxen          (itxen),
        .idat0          (idat0),
        .idat1          (idat1),
        .tx_transfer_en (status.tx_transfer_en),
        .rx_transfer_en (status.rx_transfer_en),
        .data_out0      (data_out0),
        .data_out1      (data_out1),
        .pad_tx         (pad_tx),
        .pad_rx         (pad_rx),
        .mac_rdy        (mac_rdy),
        .rstn_pad_tx    (rstn_pad_tx),
        .rstn_pad_rx    (rstn_pad_rx),
        .fs_mac_rdy     (fs_mac_rdy)
    );

endmodule

// ==== src/aib_io.sv ====
/*
 * AIB data and MAC-ready pad path
 * Registers the data word pair and mac_rdy onto the pads and
 * registers the far-side pad data back to the MAC.
 */
`timescale 1ns/1ps

module aib_io #(
    parameter int DATAWIDTH = 20
) (
    input  logic                   osc_clk,
    input  logic                   rst,
    input  logic                   itxen,
    input  logic [DATAWIDTH-1:0]   idat0,
    input  logic [DATAWIDTH-1:0]   idat1,
    input  logic                   tx_transfer_en,
    input  logic                   rx_transfer_en,
    output logic [DATAWIDTH-1:0]   data_out0,
    output logic [DATAWIDTH-1:0]   data_out1,
    output logic [2*DATAWIDTH-1:0] pad_tx,
    input  logic [2*DATAWIDTH-1:0] pad_rx,
    input  logic                   mac_rdy,
    output logic                   rstn_pad_tx,
    input  logic                   rstn_pad_rx,
    output logic                   fs_mac_rdy
);

    always_ff @(posedge osc_clk) begin
        if (rst) begin
            pad_tx <= '0;
        end else if (itxen && tx_transfer_en) begin
            pad_tx <= {idat1, idat0};
        end else begin
            pad_tx <= '0;  // idle pads low
        end
    end

    always_ff @(posedge osc_clk) begin
        if (rst || !rx_transfer_en) begin
            data_out1 <= '0;
            data_out0 <= '0;
        end else begin
            data_out1 <= pad_rx[2*DATAWIDTH-1:DATAWIDTH];
            data_out0 <= pad_rx[DATAWIDTH-1:0];
        end
    end

    always_ff @(posedge osc_clk) begin
        if (rst) begin
            rstn_pad_tx <= 1'b0;
        end else begin
            rstn_pad_tx <= mac_rdy;
        end
    end

    assign fs_mac_rdy = rstn_pad_rx;  // far side already registered it

endmodule

// ==== src/aib_link.sv ====
/*
 * AIB link top
 * Master and slave channel joined back to back by their pad wires.
 */
`timescale 1ns/1ps

module aib_link import aib_pkg::*; #(
    parameter int DATAWIDTH  = 20,
    parameter int DCC_CYCLES = 12,
    parameter int DLL_CYCLES = 20
) (
    input  logic                 osc_clk,
    input  logic                 rst,
    // master side
    input  logic                 ms_config_done,
    input  logic                 ms_tx_dcc_dll_lock_req,
    input  logic                 ms_rx_dcc_dll_lock_req,
    input  logic [MS_USER_W-1:0] ms_user_cntl,
    output logic                 ms_tx_transfer_en,
    output logic                 ms_rx_transfer_en,
    input  logic                 ms_itxen,
    input  logic [DATAWIDTH-1:0] ms_idat0,
    input  logic [DATAWIDTH-1:0] ms_idat1,
    output logic [DATAWIDTH-1:0] ms_data_out0,
    output logic [DATAWIDTH-1:0] ms_data_out1,
    input  logic                 ms_mac_rdy,
    output logic                 ms_fs_mac_rdy,
    output sl_sr_t               ms_sr_tomac,
    // slave side
    input  logic                 sl_config_done,
    input  logic                 sl_tx_dcc_dll_lock_req,
    input  logic                 sl_rx_dcc_dll_lock_req,
    input  logic [SL_USER_W-1:0] sl_user_cntl,
    output logic                 sl_tx_transfer_en,
    output logic                 sl_rx_transfer_en,
    input  logic                 sl_itxen,
    input  logic [DATAWIDTH-1:0] sl_idat0,
    input  logic [DATAWIDTH-1:0] sl_idat1,
    output logic [DATAWIDTH-1:0] sl_data_out0,
    output logic [DATAWIDTH-1:0] sl_data_out1,
    input  logic                 sl_mac_rdy,
    output logic                 sl_fs_mac_rdy,
    output ms_sr_t               sl_sr_tomac
);

    // ======================================================================
    // wires between the two channels
    // ======================================================================
    sb_pins_t               ms_sb;   // master to slave sideband
    sb_pins_t               sl_sb;   // slave to master sideband
    logic [2*DATAWIDTH-1:0] ms_pad;
    logic [2*DATAWIDTH-1:0] sl_pad;
    logic                   ms_rstn_pad;
    logic                   sl_rstn_pad;

    aib_channel #(
        .IS_MASTER  (1'b1),
        .DATAWIDTH  (DATAWIDTH),
        .DCC_CYCLES (DCC_CYCLES),
        .DLL_CYCLES (DLL_CYCLES),
        .LOC_T      (ms_sr_t),
        .FAR_T      (sl_sr_t)
    ) u_master (
        .osc_clk             (osc_clk),
        .rst                 (rst),
        .config_done         (ms_config_done),
        .tx_dcc_dll_lock_req (ms_tx_dcc_dll_lock_req),
        .rx_dcc_dll_lock_req (ms_rx_dcc_dll_lock_req),
        .user_cntl           (ms_user_cntl),
        .sr_tomac            (ms_sr_tomac),
        .tx_transfer_en      (ms_tx_transfer_en),
        .rx_transfer_en      (ms_rx_transfer_en),
        .itxen               (ms_itxen),
        .idat0               (ms_idat0),
        .idat1               (ms_idat1),
        .data_out0           (ms_data_out0),
        .data_out1           (ms_data_out1),
        .mac_rdy             (ms_mac_rdy),
        .fs_mac_rdy          (ms_fs_mac_rdy),
        .sb_tx               (ms_sb),
        .sb_rx               (sl_sb),
        .pad_tx              (ms_pad),
        .pad_rx              (sl_pad),
        .rstn_pad_tx         (ms_rstn_pad),
        .rstn_pad_rx         (sl_rstn_pad)
    );

    aib_channel #(
        .IS_MASTER  (1'b0),
        .DATAWIDTH  (DATAWIDTH),
        .DCC_CYCLES (DCC_CYCLES),
        .DLL_CYCLES (DLL_CYCLES),
        .LOC_T      (sl_sr_t),
        .FAR_T      (ms_sr_t)
    ) u_slave (
        .osc_clk             (osc_clk),
        .rst                 (rst),
        .config_done         (sl_config_done),
        .tx_dcc_dll_lock_req (sl_tx_dcc_dll_lock_req),
        .rx_dcc_dll_lock_req (sl_rx_dcc_dll_lock_req),
        .user_cntl           (sl_user_cntl),
        .sr_tomac            (sl_sr_tomac),
        .tx_transfer_en      (sl_tx_transfer_en),
        .rx_transfer_en      (sl_rx_transfer_en),
        .itxen               (sl_itxen),
        .idat0               (sl_idat0),
        .idat1               (sl_idat1),
        .data_out0           (sl_data_out0),
        .data_out1           (sl_data_out1),
        .mac_rdy             (sl_mac_rdy),
        .fs_mac_rdy          (sl_fs_mac_rdy),
        .sb_tx               (sl_sb),
        .sb_rx               (ms_sb),
        .pad_tx              (sl_pad),
        .pad_rx              (ms_pad),
        .rstn_pad_tx         (sl_rstn_pad),
        .rstn_pad_rx         (ms_rstn_pad)
    );

endmodule

// ==== src/aib_pkg.sv ====
/*
 * AIB link shared types
 * Status bits, sideband frame layouts and sideband pin bundle
 * used by both the master and the slave channel.
 */
package aib_pkg;

    // ======================================================================
    // sideband frame widths
    // ======================================================================
    localparam int MS_USER_W = 16;  // master user control bits
    localparam int SL_USER_W = 12;  // slave user control bits

    // what a channel tells the far side about itself
    typedef struct packed {
        logic osc_transfer_en;
        logic tx_dcc_cal_done;
        logic rx_dll_lock;
        logic rx_transfer_en;
        logic tx_transfer_en;
    } link_status_t;

    // master to slave frame of 21 bits
    typedef struct packed {
        link_status_t         status;
        logic [MS_USER_W-1:0] user;
    } ms_sr_t;

    // slave to master frame of 17 bits
    typedef struct packed {
        link_status_t         status;
        logic [SL_USER_W-1:0] user;
    } sl_sr_t;

    // one direction of the sideband
    typedef struct packed {
        logic data;  // serial bit sent msb first
        logic load;  // high with last bit of frame
    } sb_pins_t;

endpackage

// ==== src/aib_sideband_sr.sv ====
/*
 * AIB sideband shift register
 * Streams the local frame to the far side one bit per cycle and
 * rebuilds the far-side frame from the incoming serial bits.
 */
`timescale 1ns/1ps

module aib_sideband_sr import aib_pkg::*; #(
    parameter type TX_T = ms_sr_t,
    parameter type RX_T = sl_sr_t
) (
    input  logic     osc_clk,
    input  logic     rst,
    input  TX_T      frame_out,
    output RX_T      frame_in,
    output sb_pins_t sb_tx,
    input  sb_pins_t sb_rx
);

    localparam int TX_W  = $bits(TX_T);
    localparam int RX_W  = $bits(RX_T);
    localparam int CNT_W = $clog2(TX_W);

    logic [CNT_W-1:0] bit_cnt;
    logic [TX_W-1:0]  tx_sh;
    logic [RX_W-1:0]  rx_sh;
    logic             load_d;
    logic             last_bit;

    // ======================================================================
    // transmit
    // ======================================================================
    assign last_bit = (bit_cnt == CNT_W'(TX_W - 1));

    always_ff @(posedge osc_clk) begin
        if (rst) begin
            bit_cnt <= '0;
        end else if (last_bit) begin
            bit_cnt <= '0;  // next frame starts without a gap
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge osc_clk) begin
        if (rst || last_bit) begin
            tx_sh <= frame_out;  // snapshot of local frame
        end else begin
            tx_sh <= {tx_sh[TX_W-2:0], 1'b0};
        end
    end

    assign sb_tx.data = tx_sh[TX_W-1];  // msb first
    assign sb_tx.load = last_bit;

    // ======================================================================
    // receive
    // ======================================================================
    always_ff @(posedge osc_clk) begin
        rx_sh <= {rx_sh[RX_W-2:0], sb_rx.data};
    end

    always_ff @(posedge osc_clk) begin
        if (rst) begin
            load_d   <= 1'b0;
            frame_in <= '0;
        end else begin
            load_d <= sb_rx.load;
            if (load_d) begin
                frame_in <= RX_T'(rx_sh);  // full frame now in rx_sh
            end
        end
    end

endmodule

// ==== src/aib_sm.sv ====
/*
 * AIB link-up sequencer
 * Oscillator handshake, DCC request, DLL request and transfer
 * enables for one channel, driven by the far-side status.
 */
`timescale 1ns/1ps

module aib_sm import aib_pkg::*; #(
    parameter bit IS_MASTER = 1'b1
) (
    input  logic         osc_clk,
    input  logic         rst,
    input  logic         config_done,
    input  logic         tx_dcc_dll_lock_req,
    input  logic         rx_dcc_dll_lock_req,
    input  link_status_t far_status,
    output logic         dcc_req,
    input  logic         dcc_done,
    output logic         dll_req,
    input  logic         dll_lock,
    output link_status_t status
);

    typedef enum logic [1:0] {TX_IDLE, TX_DCC, TX_DONE, TX_EN} tx_state_t;
    typedef enum logic [1:0] {RX_IDLE, RX_DLL, RX_LOCK, RX_EN} rx_state_t;

    logic      osc_en;
    tx_state_t tx_state;
    rx_state_t rx_state;
    logic      osc_go;
    logic      tx_go;
    logic      rx_go;

    // slave waits for the master oscillator
    assign osc_go = IS_MASTER ? config_done : (config_done && far_status.osc_transfer_en);
    assign tx_go  = config_done && tx_dcc_dll_lock_req && far_status.osc_transfer_en;
    assign rx_go  = config_done && rx_dcc_dll_lock_req && far_status.tx_dcc_cal_done;

    // ======================================================================
    // oscillator, transmit and receive sequencers
    // ======================================================================
    always_ff @(posedge osc_clk) begin
        if (rst) begin
            osc_en <= 1'b0;
        end else begin
            osc_en <= osc_go;
        end
    end

    // on a lost condition each machine steps back one state per cycle
    always_ff @(posedge osc_clk) begin
        if (rst) begin
            tx_state <= TX_IDLE;
        end else begin
            case (tx_state)
                TX_IDLE: if (tx_go) tx_state <= TX_DCC;
                TX_DCC: begin
                    if (!tx_go) tx_state <= TX_IDLE;
                    else if (dcc_done) tx_state <= TX_DONE;
                end
                TX_DONE: begin
                    if (!tx_go) tx_state <= TX_DCC;
                    else if (far_status.rx_transfer_en) tx_state <= TX_EN;
                end
                default: begin
                    if (!tx_go || !far_status.rx_transfer_en) tx_state <= TX_DONE;
                end
            endcase
        end
    end

    always_ff @(posedge osc_clk) begin
        if (rst) begin
            rx_state <= RX_IDLE;
        end else begin
            case (rx_state)
                RX_IDLE: if (rx_go) rx_state <= RX_DLL;
                RX_DLL: begin
                    if (!rx_go) rx_state <= RX_IDLE;
                    else if (dll_lock) rx_state <= RX_LOCK;
                end
                RX_LOCK: rx_state <= rx_go ? RX_EN : RX_DLL;
                default: if (!rx_go) rx_state <= RX_LOCK;
            endcase
        end
    end

    // ======================================================================
    // outputs
    // ======================================================================
    assign dcc_req = (tx_state != TX_IDLE);  // held so done stays up
    assign dll_req = (rx_state != RX_IDLE);

    assign status.osc_transfer_en = osc_en;
    assign status.tx_dcc_cal_done = (tx_state == TX_DONE) || (tx_state == TX_EN);
    assign status.rx_dll_lock     = (rx_state == RX_LOCK) || (rx_state == RX_EN);
    assign status.rx_transfer_en  = (rx_state == RX_EN);
    assign status.tx_transfer_en  = (tx_state == TX_EN);

endmodule

// ==== test/tb_aib_cases.svh ====
/*
 * AIB link test tables
 * Data word pairs and user control values with their expected images.
 */
`ifndef TB_AIB_CASES_SVH
`define TB_AIB_CASES_SVH

localparam int N_DATA = 8;
localparam int N_USER = 4;

// master sends {d1,d0} and slave sends {d0,d1} in one transfer
typedef struct packed {
    logic [DATAWIDTH-1:0] d0;
    logic [DATAWIDTH-1:0] d1;
} data_case_t;

// user fields land unchanged in the far image
typedef struct packed {
    logic [MS_USER_W-1:0] ms_user;
    logic [SL_USER_W-1:0] sl_user;
    link_status_t         exp_status;  // status in both images once the link is up
} user_case_t;

data_case_t data_cases [N_DATA];
user_case_t user_cases [N_USER];

task automatic build_cases();
    data_cases[0] = '{d0: '0, d1: '1};
    data_cases[1] = '{d0: '1, d1: '1};
    data_cases[2] = '{d0: {(DATAWIDTH/2){2'b10}}, d1: {(DATAWIDTH/2){2'b01}}};
    data_cases[3] = '{d0: DATAWIDTH'(1), d1: DATAWIDTH'(1) << (DATAWIDTH - 1)};
    for (int i = 4; i < N_DATA; i++) begin
        data_cases[i].d0 = DATAWIDTH'($urandom);  // random fill
        data_cases[i].d1 = DATAWIDTH'($urandom);
    end
    user_cases[0] = '{ms_user: '1, sl_user: '0, exp_status: '1};
    user_cases[1] = '{ms_user: 16'ha5c3, sl_user: 12'h5a6, exp_status: '1};
    for (int i = 2; i < N_USER; i++) begin
        user_cases[i].ms_user    = MS_USER_W'($urandom);
        user_cases[i].sl_user    = SL_USER_W'($urandom);
        user_cases[i].exp_status = '1;
    end
endtask

`endif

// ==== test/tb_aib_link.sv ====
/*
 * AIB link testbench
 * Brings the master/slave link up and checks sideband images,
 * data path, MAC-ready and transfer enable gating.
 */
`timescale 1ns/1ps

module tb_aib_link import aib_pkg::*; ();

    localparam int DATAWIDTH  = 20;
    localparam int DCC_CYCLES = 12;
    localparam int DLL_CYCLES = 20;
    localparam int RST_CYCLES = 8;
    localparam int MS_W       = $bits(ms_sr_t);
    localparam int SB_WAIT    = 2 * MS_W + 2;  // frame input to far image
    localparam int RAND_SEED  = 32'hdaeb;

`include "tb_aib_cases.svh"

    localparam int LIMIT = 4 * (DCC_CYCLES + DLL_CYCLES + 4 * MS_W)
                         + 3 * N_DATA + N_USER * SB_WAIT + 200;

    logic                 osc_clk = 1'b0;
    logic                 rst;
    logic                 ms_config_done, sl_config_done;
    logic                 ms_tx_dcc_dll_lock_req, sl_tx_dcc_dll_lock_req;
    logic                 ms_rx_dcc_dll_lock_req, sl_rx_dcc_dll_lock_req;
    logic [MS_USER_W-1:0] ms_user_cntl;
    logic [SL_USER_W-1:0] sl_user_cntl;
    logic                 ms_tx_transfer_en, sl_tx_transfer_en;
    logic                 ms_rx_transfer_en, sl_rx_transfer_en;
    logic                 ms_itxen, sl_itxen;
    logic [DATAWIDTH-1:0] ms_idat0, ms_idat1, sl_idat0, sl_idat1;
    logic [DATAWIDTH-1:0] ms_data_out0, ms_data_out1, sl_data_out0, sl_data_out1;
    logic                 ms_mac_rdy, sl_mac_rdy;
    logic                 ms_fs_mac_rdy, sl_fs_mac_rdy;
    sl_sr_t               ms_sr_tomac;
    ms_sr_t               sl_sr_tomac;

    int   error_count = 0;
    int   check_count = 0;
    int   cycle_count = 0;
    logic order_watch = 1'b0;  // enable ordering monitor

    aib_link #(
        .DATAWIDTH  (DATAWIDTH),
        .DCC_CYCLES (DCC_CYCLES),
        .DLL_CYCLES (DLL_CYCLES)
    ) DUT (.*);

    always #50 osc_clk = ~osc_clk;

    // ======================================================================
    // compare tasks
    // ======================================================================
    task automatic check_bit(input string what, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_data(input string what, input logic [DATAWIDTH-1:0] got,
                              input logic [DATAWIDTH-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_frame(input string what, input link_status_t got_st,
                               input link_status_t exp_st,
                               input logic [MS_USER_W-1:0] got_user,
                               input logic [MS_USER_W-1:0] exp_user);
        check_count++;
        if (got_st !== exp_st || got_user !== exp_user) begin
            error_count++;
            $display("[FAIL] %0d ns: %s is %b/%h, expected %b/%h", $time, what,
                     got_st, got_user, exp_st, exp_user);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge osc_clk);
    endtask

    // tx enable must never lead the far rx enable
    always @(negedge osc_clk) begin
        if (order_watch && ms_tx_transfer_en && !sl_rx_transfer_en) begin
            error_count++;
            $display("[FAIL] %0d ns: ms_tx_transfer_en high while sl_rx_transfer_en low",
                     $time);
        end
        if (order_watch && sl_tx_transfer_en && !ms_rx_transfer_en) begin
            error_count++;
            $display("[FAIL] %0d ns: sl_tx_transfer_en high while ms_rx_transfer_en low",
                     $time);
        end
    end

    always @(posedge osc_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= LIMIT) begin
            $display("Timeout: the run did not finish within %0d clock cycles", LIMIT);
            $display("%0d checks, %0d errors", check_count, error_count);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ======================================================================
    // test sequence
    // ======================================================================
    initial begin
        int unsigned seed_val;
        int          rx_low_at;
        int          data_low_at;
        seed_val = $urandom(RAND_SEED);
        build_cases();
        rst = 1'b1;
        {ms_config_done, sl_config_done} = '0;
        {ms_tx_dcc_dll_lock_req, sl_tx_dcc_dll_lock_req} = '0;
        {ms_rx_dcc_dll_lock_req, sl_rx_dcc_dll_lock_req} = '0;
        ms_user_cntl = '0;
        sl_user_cntl = '0;
        {ms_itxen, sl_itxen} = '0;
        {ms_idat0, ms_idat1, sl_idat0, sl_idat1} = '0;
        {ms_mac_rdy, sl_mac_rdy} = '0;
        wait_cycles(RST_CYCLES);
        rst = 1'b0;
        @(negedge osc_clk);

        // idle after reset
        check_bit("ms_tx_transfer_en", ms_tx_transfer_en, 1'b0);
        check_bit("ms_rx_transfer_en", ms_rx_transfer_en, 1'b0);
        check_bit("sl_tx_transfer_en", sl_tx_transfer_en, 1'b0);
        check_bit("sl_rx_transfer_en", sl_rx_transfer_en, 1'b0);
        check_bit("ms_fs_mac_rdy", ms_fs_mac_rdy, 1'b0);
        check_bit("sl_fs_mac_rdy", sl_fs_mac_rdy, 1'b0);
        check_data("ms_data_out0", ms_data_out0, '0);
        check_data("ms_data_out1", ms_data_out1, '0);
        check_data("sl_data_out0", sl_data_out0, '0);
        check_data("sl_data_out1", sl_data_out1, '0);
        wait_cycles(3 * MS_W);
        check_frame("sl_sr_tomac after reset", sl_sr_tomac.status, '0, sl_sr_tomac.user, '0);
        check_frame("ms_sr_tomac after reset", ms_sr_tomac.status, '0,
                    MS_USER_W'(ms_sr_tomac.user), '0);

        // bring-up
        {ms_config_done, sl_config_done} = 2'b11;
        {ms_tx_dcc_dll_lock_req, sl_tx_dcc_dll_lock_req} = 2'b11;
        {ms_rx_dcc_dll_lock_req, sl_rx_dcc_dll_lock_req} = 2'b11;
        order_watch = 1'b1;
        while (!(ms_tx_transfer_en && ms_rx_transfer_en &&
                 sl_tx_transfer_en && sl_rx_transfer_en)) begin
            @(negedge osc_clk);
        end
        $display("link up after %0d cycles", cycle_count);

        // user bits through the sideband
        for (int n = 0; n < N_USER; n++) begin
            ms_user_cntl = user_cases[n].ms_user;
            sl_user_cntl = user_cases[n].sl_user;
            wait_cycles(SB_WAIT);
            check_frame($sformatf("sl_sr_tomac, case %0d", n), sl_sr_tomac.status,
                        user_cases[n].exp_status, sl_sr_tomac.user, user_cases[n].ms_user);
            check_frame($sformatf("ms_sr_tomac, case %0d", n), ms_sr_tomac.status,
                        user_cases[n].exp_status, MS_USER_W'(ms_sr_tomac.user),
                        MS_USER_W'(user_cases[n].sl_user));
        end

        // data both ways with one entry per cycle
        {ms_itxen, sl_itxen} = 2'b11;
        for (int i = 0; i < N_DATA + 2; i++) begin
            if (i >= 2) begin
                check_data($sformatf("sl_data_out0, case %0d", i - 2), sl_data_out0,
                           data_cases[i-2].d0);
                check_data($sformatf("sl_data_out1, case %0d", i - 2), sl_data_out1,
                           data_cases[i-2].d1);
                check_data($sformatf("ms_data_out0, case %0d", i - 2), ms_data_out0,
                           data_cases[i-2].d1);
                check_data($sformatf("ms_data_out1, case %0d", i - 2), ms_data_out1,
                           data_cases[i-2].d0);
            end
            if (i < N_DATA) begin
                {ms_idat1, ms_idat0} = {data_cases[i].d1, data_cases[i].d0};
                {sl_idat1, sl_idat0} = {data_cases[i].d0, data_cases[i].d1};
            end
            @(negedge osc_clk);
        end

        // mac_rdy crosses in one cycle
        for (int k = 0; k < 8; k++) begin
            ms_mac_rdy = k[0];
            sl_mac_rdy = ~k[1];
            @(negedge osc_clk);
            check_bit("sl_fs_mac_rdy", sl_fs_mac_rdy, ms_mac_rdy);
            check_bit("ms_fs_mac_rdy", ms_fs_mac_rdy, sl_mac_rdy);
        end

        // itxen low idles the pads
        {ms_itxen, sl_itxen} = 2'b00;
        wait_cycles(2);
        check_data("sl_data_out0, itxen low", sl_data_out0, '0);
        check_data("sl_data_out1, itxen low", sl_data_out1, '0);
        check_data("ms_data_out0, itxen low", ms_data_out0, '0);
        check_data("ms_data_out1, itxen low", ms_data_out1, '0);

        // dropping the rx lock request gates the master receiver
        order_watch = 1'b0;
        sl_itxen = 1'b1;
        {sl_idat1, sl_idat0} = {data_cases[1].d1, data_cases[1].d0};
        wait_cycles(2);
        check_data("ms_data_out0 before drop", ms_data_out0, data_cases[1].d0);
        ms_rx_dcc_dll_lock_req = 1'b0;
        rx_low_at   = -1;
        data_low_at = -1;
        for (int c = 0; c < DLL_CYCLES + 2; c++) begin
            @(negedge osc_clk);
            if (rx_low_at < 0 && !ms_rx_transfer_en) rx_low_at = c;
            if (data_low_at < 0 && ms_data_out0 == '0 && ms_data_out1 == '0) begin
                data_low_at = c;
            end
        end
        check_bit("ms_rx_transfer_en after drop", ms_rx_transfer_en, 1'b0);
        check_data("ms_data_out0 after drop", ms_data_out0, '0);
        check_data("ms_data_out1 after drop", ms_data_out1, '0);
        check_bit("ms data cleared after ms_rx_transfer_en",
                  (rx_low_at >= 0) && (data_low_at > rx_low_at), 1'b1);

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
